// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - mips_alu.sv
      - mips_reg_file.sv
      - mips_control.sv
      - mips_cpu_bus.sv
  - target: test
    files:
      - mips_tb_memory.sv
      - mips_cpu_bus_tb.sv

// File: mips_alu.sv
// MIPS ALU
// decodes opcode and funct into an operation, picks the second
// operand and produces the result combinationally

`timescale 1ns/10ps
`default_nettype none

module mips_alu (
    input  mips_pkg::instr_t instr,
    input  logic [31:0]      rs_val,
    input  logic [31:0]      rt_val,
    output logic [31:0]      alu_result
);

    mips_pkg::instr_u  view;
    mips_pkg::alu_op_t op;
    logic [31:0]       operand_b;

    // same word, seen through the I-type layout for the immediate
    assign view = mips_pkg::instr_u'(instr);

    // JR forwards rs, everything else adds
    always_comb begin
        if (instr.opcode == mips_pkg::OPCODE_RTYPE && instr.funct == mips_pkg::FUNCT_JR) begin
            op = mips_pkg::ALU_PASS_A;
        end else begin
            op = mips_pkg::ALU_ADD;
        end
    end

    // register operand for R-type, zero-extended immediate otherwise
    always_comb begin
        if (instr.opcode == mips_pkg::OPCODE_RTYPE) begin
            operand_b = rt_val;
        end else begin
            operand_b = {16'b0, view.i.imm};
        end
    end

    always_comb begin
        case (op)
            mips_pkg::ALU_PASS_A: begin
                alu_result = rs_val;
            end
            default: begin
                // wraps, no overflow trap
                alu_result = rs_val + operand_b;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mips_control.sv
// MIPS control unit
// four-state FSM with pc and ir, instruction decode, register
// write selection and the Avalon master signals

`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module mips_control (
    input  logic                 clk,
    input  logic                 reset,
    output logic [31:0]          address,
    output logic                 read,
    output logic                 write,
    output logic [31:0]          writedata,
    output logic [3:0]           byteenable,
    input  logic                 waitrequest,
    input  logic [31:0]          readdata,
    output logic                 active,
    output mips_pkg::instr_t     instr,
    output logic [4:0]           rs_idx,
    output logic [4:0]           rt_idx,
    input  logic [31:0]          rs_val,
    input  logic [31:0]          rt_val,
    input  logic [31:0]          alu_result,
    output mips_pkg::reg_write_t reg_wr
);

    mips_pkg::state_t  state;
    logic [31:0]       pc;
    mips_pkg::instr_u  ir;
    logic [31:0]       load_data;

    mips_pkg::opcode_t opcode;
    logic [31:0]       pc_plus4;
    logic [31:0]       jump_target;
    logic              is_jump;
    logic              is_jr;
    logic              is_load;
    logic              is_mem_op;
    logic              exec_writes;

    assign opcode   = ir.r.opcode;
    assign pc_plus4 = pc + 32'd4;

    // pseudo-direct target keeps the top nibble of the next pc
    assign jump_target = {pc_plus4[31:28], ir.j.target, 2'b00};

    assign is_jump   = (opcode == mips_pkg::OPCODE_J) || (opcode == mips_pkg::OPCODE_JAL);
    assign is_jr     = (opcode == mips_pkg::OPCODE_RTYPE) && (ir.r.funct == mips_pkg::FUNCT_JR);
    assign is_load   = (opcode == mips_pkg::OPCODE_LW);
    assign is_mem_op = is_load || (opcode == mips_pkg::OPCODE_SW);

    assign instr  = ir.r;
    assign rs_idx = ir.r.rs;
    assign rt_idx = ir.r.rt;

    // instructions that retire a register write in EXECUTE
    always_comb begin
        case (opcode)
            mips_pkg::OPCODE_RTYPE: begin
                exec_writes = (ir.r.funct == mips_pkg::FUNCT_ADDU);
            end
            mips_pkg::OPCODE_ADDIU, mips_pkg::OPCODE_JAL: begin
                exec_writes = 1'b1;
            end
            default: begin
                // unknown opcodes fall through as no-ops
                exec_writes = 1'b0;
            end
        endcase
    end

    // destination and data for the register file
    always_comb begin
        reg_wr.en = ((state == mips_pkg::STATE_EXECUTE) && exec_writes)
                 || (state == mips_pkg::STATE_WRITEBACK);

        case (opcode)
            mips_pkg::OPCODE_RTYPE: begin
                reg_wr.addr = ir.r.rd;
            end
            mips_pkg::OPCODE_JAL: begin
                reg_wr.addr = `MIPS_REG_RA;
            end
            default: begin
                reg_wr.addr = ir.r.rt;
            end
        endcase

        if (state == mips_pkg::STATE_WRITEBACK) begin
            reg_wr.data = load_data;
        end else if (opcode == mips_pkg::OPCODE_JAL) begin
            // link to the instruction right after the JAL
            reg_wr.data = pc_plus4;
        end else begin
            reg_wr.data = alu_result;
        end
    end

    // bus master outputs hold steady while waitrequest is high
    assign active     = (pc != `MIPS_HALT_ADDR);
    assign address    = (state == mips_pkg::STATE_MEMORY) ? alu_result : pc;
    // no requests while reset is high
    assign read       = active && !reset && ((state == mips_pkg::STATE_FETCH)
                     || ((state == mips_pkg::STATE_MEMORY) && is_load));
    assign write      = active && !reset && (state == mips_pkg::STATE_MEMORY)
                     && (opcode == mips_pkg::OPCODE_SW);
    assign writedata  = rt_val;
    assign byteenable = `MIPS_BYTE_ENABLE_ALL;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `MIPS_RESET_VECTOR;
            state <= mips_pkg::STATE_FETCH;
        end else if (active) begin
            case (state)
                mips_pkg::STATE_FETCH: begin
                    if (!waitrequest) begin
                        state <= mips_pkg::STATE_EXECUTE;
                    end
                end
                mips_pkg::STATE_EXECUTE: begin
                    if (is_jump) begin
                        pc <= jump_target;
                    end else if (is_jr) begin
                        pc <= rs_val;
                    end else begin
                        pc <= pc_plus4;
                    end
                    if (is_mem_op) begin
                        state <= mips_pkg::STATE_MEMORY;
                    end else begin
                        state <= mips_pkg::STATE_FETCH;
                    end
                end
                mips_pkg::STATE_MEMORY: begin
                    if (!waitrequest) begin
                        if (is_load) begin
                            state <= mips_pkg::STATE_WRITEBACK;
                        end else begin
                            state <= mips_pkg::STATE_FETCH;
                        end
                    end
                end
                default: begin
                    // writeback is a single cycle
                    state <= mips_pkg::STATE_FETCH;
                end
            endcase
        end
    end

    // readdata is captured in the cycle the transfer completes
    always_ff @(posedge clk) begin
        if (read && !waitrequest) begin
            if (state == mips_pkg::STATE_FETCH) begin
                ir <= mips_pkg::instr_u'(readdata);
            end else begin
                load_data <= readdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: mips_cpu_bus.sv
// MIPS CPU with Avalon master
// connects the control unit, register file and ALU to the
// memory-mapped bus and the status outputs

`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    mips_pkg::instr_t     instr;
    mips_pkg::reg_write_t reg_wr;
    logic [4:0]           rs_idx;
    logic [4:0]           rt_idx;
    logic [31:0]          rs_val;
    logic [31:0]          rt_val;
    logic [31:0]          alu_result;

    mips_control i_control (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .instr       (instr),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .alu_result  (alu_result),
        .reg_wr      (reg_wr)
    );

    mips_reg_file i_reg_file (
        .clk         (clk),
        .reset       (reset),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .reg_wr      (reg_wr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .register_v0 (register_v0)
    );

    mips_alu i_alu (
        .instr      (instr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .alu_result (alu_result)
    );

endmodule

`default_nettype wire

// File: mips_cpu_bus_tb.sv
// MIPS CPU testbench
// runs the programs from the stimulus file on the core with a
// wait-state memory, then checks v0, memory and an idle bus

`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus_tb;

    localparam int STAGES      = 4;
    localparam int MAX_WAIT    = 3;
    localparam int MARGIN      = 20;
    localparam int IDLE_CYCLES = 10;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;

    int          mismatch_count = 0;
    int          fault_count = 0;
    int          timeout_count = 0;
    int          tests_run = 0;
    int          image_words = 0;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    mips_cpu_bus i_mips_cpu_bus (.*);

    mips_tb_memory i_memory (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // once halted the core must leave the bus alone
    always @(negedge clk) begin
        if (!reset && active === 1'b0) begin
            assert (!read && !write) else begin
                $display("bus transfer after halt: read=%b write=%b address=%h",
                         read, write, address);
                fault_count++;
            end
        end
        if (!reset && (read || write)) begin
            assert (byteenable == 4'b1111) else begin
                $display("transfer with partial byteenable %b", byteenable);
                fault_count++;
            end
        end
    end

    // starts at time 0 or on a falling edge
    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!read && !write) else begin
                $display("bus request while reset is high: read=%b write=%b",
                         read, write);
                fault_count++;
            end
        end
        reset = 1'b0;
    endtask

    task automatic run_test(input string name, input logic [31:0] exp_v0);
        int          limit;
        int          cycles;
        logic [31:0] actual;
        // worst case stretches every stage of every word by the longest wait
        limit = image_words * STAGES * MAX_WAIT + MARGIN;
        cycles = 0;
        tests_run++;
        apply_reset();
        assert (active === 1'b1) else begin
            $display("core not active after reset in %0s", name);
            fault_count++;
        end
        while (active && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("timeout: %0s still running after %0d cycles", name, cycles);
            timeout_count++;
        end else begin
            repeat (IDLE_CYCLES) @(negedge clk);
            assert (register_v0 == exp_v0) else begin
                $display("mismatch %0s register_v0: expected %h, actual %h",
                         name, exp_v0, register_v0);
                mismatch_count++;
            end
            for (int i = 0; i < exp_addr.size(); i++) begin
                actual = i_memory.peek_word(exp_addr[i]);
                assert (actual == exp_data[i]) else begin
                    $display("mismatch %0s mem[%h]: expected %h, actual %h",
                             name, exp_addr[i], exp_data[i], actual);
                    mismatch_count++;
                end
            end
        end
        image_words = 0;
        exp_addr.delete();
        exp_data.delete();
        i_memory.clear_all();
    endtask

    task automatic handle_line(input string line);
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        string       name;
        int          n;
        kind = line.getc(0);
        if (kind == "M" || kind == "E") begin
            n = $sscanf(line, "%c %h %h", kind, a, d);
            if (n != 3) begin
                $display("malformed stimulus line: %0s", line);
                fault_count++;
            end else if (kind == "M") begin
                i_memory.load_word(a, d);
                image_words++;
            end else begin
                exp_addr.push_back(a);
                exp_data.push_back(d);
            end
        end else if (kind == "R") begin
            n = $sscanf(line, "R %s %h", name, d);
            if (n != 2) begin
                $display("malformed stimulus line: %0s", line);
                fault_count++;
            end else begin
                run_test(name, d);
            end
        end
    endtask

    initial begin
        int    fd;
        string line;
        i_memory.clear_all();
        fd = $fopen("mips_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file mips_stimulus.txt");
            fault_count++;
        end else begin
            while (!$feof(fd) && timeout_count == 0) begin
                if ($fgets(line, fd) > 0) begin
                    handle_line(line);
                end
            end
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no test was run from the stimulus file");
            fault_count++;
        end
        $display("errors: %0d mismatches, %0d faults, %0d timeouts",
                 mismatch_count, fault_count, timeout_count);
        if (mismatch_count + fault_count + timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_defs.svh
// MIPS core constants
// boot vector, halt address and fixed register indices shared by
// the control unit and the register file

`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// pc value loaded on reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// jumping here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// v0, exported for observation
`define MIPS_REG_V0 5'd2

// ra, link register written by JAL
`define MIPS_REG_RA 5'd31

// all byte lanes on every transfer
`define MIPS_BYTE_ENABLE_ALL 4'b1111

`endif

// File: mips_pkg.sv
// MIPS core types
// opcode, funct, FSM state and ALU operation encodings, plus the
// instruction word layouts and the register write bundle

`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OPCODE_RTYPE = 6'b00_0000,
        OPCODE_J     = 6'b00_0010,
        OPCODE_JAL   = 6'b00_0011,
        OPCODE_ADDIU = 6'b00_1001,
        OPCODE_LW    = 6'b10_0011,
        OPCODE_SW    = 6'b10_1011
    } opcode_t;

    typedef enum logic [5:0] {
        FUNCT_JR   = 6'b00_1000,
        FUNCT_ADDU = 6'b10_0001
    } funct_t;

    typedef enum logic [1:0] {
        STATE_FETCH     = 2'd0,
        STATE_EXECUTE   = 2'd1,
        STATE_MEMORY    = 2'd2,
        STATE_WRITEBACK = 2'd3
    } state_t;

    typedef enum logic {
        ALU_ADD    = 1'b0,
        ALU_PASS_A = 1'b1
    } alu_op_t;

    // R-type view of the word
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

    // I-type view
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } itype_t;

    // J-type view
    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } jtype_t;

    typedef union packed {
        instr_t r;
        itype_t i;
        jtype_t j;
    } instr_u;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

// File: mips_reg_file.sv
// MIPS register file
// 32 x 32 bits, two combinational read ports and one write port,
// register 0 reads as zero and v0 is exported

`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module mips_reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [4:0]           rs_idx,
    input  logic [4:0]           rt_idx,
    input  mips_pkg::reg_write_t reg_wr,
    output logic [31:0]          rs_val,
    output logic [31:0]          rt_val,
    output logic [31:0]          register_v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.en && reg_wr.addr != 5'd0) begin
            // $zero never changes
            regs[reg_wr.addr] <= reg_wr.data;
        end
    end

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    assign register_v0 = regs[`MIPS_REG_V0];

endmodule

`default_nettype wire

// File: mips_stimulus.txt
# M addr word = image word, E addr word = expected memory word after halt
# R name v0 = run the lines above and expect v0, all values in hex
M bfc00000 8c080800
M bfc00004 2409ffff
M bfc00008 01091021
M bfc0000c 00000008
M 00000800 fffffff0
R addu_wrap 0000ffef
M bfc00000 2408beef
M bfc00004 24090804
M bfc00008 ad280004
M bfc0000c 8d220004
M bfc00010 00000008
E 00000808 0000beef
R sw_lw 0000beef
M bfc00000 24020005
M bfc00004 0bf00003
M bfc00008 24420100
M bfc0000c 24420001
M bfc00010 00000008
R j_skip 00000006
M bfc00000 0ff00003
M bfc00004 24420010
M bfc00008 00000008
M bfc0000c 03e01021
M bfc00010 03e00008
R jal_jr bfc00014
M bfc00000 24020077
M bfc00004 24000055
M bfc00008 00001021
M bfc0000c 00000008
R zero_reg 00000000
M bfc00000 24020042
M bfc00004 00000008
M bfc00008 24420001
R halt_idle 00000042

// File: mips_tb_memory.sv
// testbench Avalon slave memory
// word array with random wait states per transfer, plus tasks
// to load a program image and read words back after a run

`timescale 1ns/10ps
`default_nettype none

module mips_tb_memory (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    localparam logic [31:0] LCG_SEED = 32'd7631;

    // 4 KB window that the upper address bits alias onto
    logic [31:0] mem [1024];
    logic [31:0] lcg_state;
    logic        busy;
    int unsigned wait_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic clear_all();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = '0;
        end
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] = data;
    endtask

    function automatic logic [31:0] peek_word(input logic [31:0] addr);
        return mem[addr[11:2]];
    endfunction

    initial begin
        lcg_state   = LCG_SEED;
        busy        = 1'b0;
        wait_left   = 0;
        waitrequest = 1'b1;
        readdata    = '0;
    end

    // responses change on the falling edge and are sampled on the rising one
    always @(negedge clk) begin
        int unsigned left;
        if (reset || !(read || write)) begin
            busy        <= 1'b0;
            waitrequest <= 1'b1;
        end else begin
            if (busy) begin
                left = wait_left;
            end else begin
                // a new transfer draws 0 to 2 wait states
                lcg_state = lcg_next(lcg_state);
                left = lcg_state[31:16] % 3;
            end
            if (left == 0) begin
                busy        <= 1'b0;
                waitrequest <= 1'b0;
                if (write) begin
                    mem[address[11:2]] = writedata;
                end else begin
                    readdata <= mem[address[11:2]];
                end
            end else begin
                busy        <= 1'b1;
                waitrequest <= 1'b1;
                wait_left   <= left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
mips_pkg.sv
mips_alu.sv
mips_reg_file.sv
mips_control.sv
mips_cpu_bus.sv
mips_tb_memory.sv
mips_cpu_bus_tb.sv
